/* hw/uart_pkg.sv */
package uart_pkg;

  // bus request from the master.
  typedef struct packed {
    logic        read;        // read strobe.
    logic        write;       // write strobe.
    logic [3:0]  address;     // byte address, 3:2 picks the register.
    logic [31:0] write_data;
  } avl_req_t;

  // bus response back to the master.
  typedef struct packed {
    logic        request_ready;    // tied high, no wait states.
    logic        read_data_valid;  // one cycle after the read.
    logic [31:0] read_data;
  } avl_rsp_t;

  // register select, word aligned.
  typedef enum logic [1:0] {
    reg_div    = 2'd0,  // baud divisor.
    reg_status = 2'd1,  // flags.
    reg_data   = 2'd2,  // tx on write, rx on read.
    reg_count  = 2'd3   // good frames seen.
  } reg_addr_e;

  // receiver states.
  typedef enum logic [1:0] {
    rx_idle,   // line high, waiting for an edge.
    rx_start,  // half bit into the start bit.
    rx_bits,   // eight data samples.
    rx_stop    // stop bit sample.
  } rx_state_e;

  // one received frame as handed to the registers.
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;  // stop bit read low.
  } rx_frame_t;

  // status word bit positions.
  localparam int st_tx_idle   = 0;  // transmitter free.
  localparam int st_rx_valid  = 1;  // unread byte waiting.
  localparam int st_frame_err = 2;  // sticky, cleared on status read.
  localparam int st_overrun   = 3;  // sticky, cleared on status read.

  // the 8n1 frame.
  // start bit low, data lsb first, stop bit high.
  // every bit lasts div+1 clocks.

endpackage

/* hw/uart_regs.sv */
`timescale 1ns/1ps

module uart_regs #(
  parameter int div_width = 16
) (
  input  logic                   clk,
  input  logic                   rest,
  input  uart_pkg::avl_req_t     avl_req,
  output uart_pkg::avl_rsp_t     avl_rsp,
  output logic [div_width-1:0]   div,
  output logic [7:0]             tx_byte,
  output logic                   tx_start,
  input  logic                   tx_idle,
  input  logic                   frame_valid,
  input  uart_pkg::rx_frame_t    frame
);
  import uart_pkg::*;

  reg_addr_e   sel;          // decoded register.
  logic        wr_data;      // write to the data register.
  logic        rd_data_reg;  // read of the data register.
  logic        rd_status;    // read of the status word.
  logic [31:0] status;

  logic        rx_valid;
  logic        frame_err;
  logic        overrun;
  logic [7:0]  rx_data;      // last good byte.
  logic [7:0]  rx_count;     // wraps at 256.

  logic        rsp_valid;
  logic [31:0] rsp_data;

  assign sel         = reg_addr_e'(avl_req.address[3:2]);
  assign wr_data     = avl_req.write && (sel == reg_data);
  assign rd_data_reg = avl_req.read && (sel == reg_data);
  assign rd_status   = avl_req.read && (sel == reg_status);

  always_comb begin
    status               = '0;
    status[st_tx_idle]   = tx_idle;
    status[st_rx_valid]  = rx_valid;
    status[st_frame_err] = frame_err;
    status[st_overrun]   = overrun;
  end

  // divisor register.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      div <= '0;
    end else if (avl_req.write && (sel == reg_div)) begin
      div <= avl_req.write_data[div_width-1:0];
    end
  end

  // start pulse comes one cycle after the write.
  // the guard on tx_start stops a back to back write from restarting.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      tx_start <= 1'b0;
    end else begin
      tx_start <= wr_data && tx_idle && !tx_start;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_data && tx_idle && !tx_start) tx_byte <= avl_req.write_data[7:0]; // busy writes dropped.
  end

  // receive flags and counter.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
      overrun   <= 1'b0;
      rx_count  <= '0;
    end else begin
      if (rd_data_reg) rx_valid <= 1'b0;  // byte consumed.
      if (rd_status) begin
        frame_err <= 1'b0;  // read then clear.
        overrun   <= 1'b0;
      end
      // a new frame wins over a clear in the same cycle.
      if (frame_valid) begin
        if (frame.frame_err) begin
          frame_err <= 1'b1;
        end else begin
          rx_valid <= 1'b1;
          rx_count <= rx_count + 8'd1;
          if (rx_valid && !rd_data_reg) overrun <= 1'b1; // old byte lost.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_valid && !frame.frame_err) rx_data <= frame.data; // bad frames discarded.
  end

  // registered read path.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= avl_req.read;
    end
  end

  always_ff @(posedge clk) begin
    if (avl_req.read) begin
      case (sel)
        reg_div:    rsp_data <= 32'(div);
        reg_status: rsp_data <= status;
        reg_data:   rsp_data <= {24'd0, rx_data};
        reg_count:  rsp_data <= {24'd0, rx_count};
        default:    rsp_data <= '0;
      endcase
    end
  end

  assign avl_rsp.request_ready   = 1'b1;
  assign avl_rsp.read_data_valid = rsp_valid;
  assign avl_rsp.read_data       = rsp_data;

  // master must not issue both strobes at once.
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rest)
    !(avl_req.read && avl_req.write));

  // start only reaches the transmitter while it is free.
  a_start_idle: assert property (@(posedge clk) disable iff (!rest)
    tx_start |-> tx_idle);

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int div_width = 16
) (
  input  logic                 clk,
  input  logic                 rest,
  input  logic [div_width-1:0] div,
  input  logic                 tx_start,
  input  logic [7:0]           tx_byte,
  output logic                 tx,
  output logic                 tx_idle
);

  logic [div_width-1:0] baud_cnt;  // clocks into the current bit.
  logic [3:0]           bit_idx;   // 0..9 sending, 10 idle.
  logic [9:0]           frame;     // stop, data, start.
  logic                 bit_end;

  assign bit_end = (baud_cnt == div);
  assign tx_idle = (bit_idx == 4'd10);

  // baud counter.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      baud_cnt <= '0;
    end else if (tx_start || bit_end) begin
      baud_cnt <= '0;  // reload.
    end else if (!tx_idle) begin
      baud_cnt <= baud_cnt + div_width'(1);
    end
  end

  // bit index parks at 10 when done.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      bit_idx <= 4'd10;
    end else if (tx_start) begin
      bit_idx <= 4'd0;
    end else if (bit_end && !tx_idle) begin
      bit_idx <= bit_idx + 4'd1;
    end
  end

  // frame captured on the start pulse.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      frame <= '1;  // all at the stop level.
    end else if (tx_start) begin
      frame <= {1'b1, tx_byte, 1'b0};
    end
  end

  // idle shows the stop bit to keep the line high.
  assign tx = frame[tx_idle ? 4'd9 : bit_idx];

  // no stray low bit outside a frame.
  a_idle_high: assert property (@(posedge clk) disable iff (!rest)
    tx_idle |-> tx);

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int div_width = 16
) (
  input  logic                 clk,
  input  logic                 rest,
  input  logic [div_width-1:0] div,
  input  logic                 rx,
  output logic                 frame_valid,
  output uart_pkg::rx_frame_t  frame
);
  import uart_pkg::*;

  rx_state_e            state;
  logic                 rx_meta;   // first sync stage.
  logic                 rx_sync;   // second sync stage.
  logic                 rx_prev;   // for edge detect.
  logic                 fall;
  logic [div_width-1:0] baud_cnt;
  logic [div_width:0]   half_bit;  // (div+1)/2.
  logic                 mid_hit;
  logic                 bit_end;
  logic [2:0]           bit_cnt;   // data bit number.
  logic [7:0]           shift;

  // two flop synchronizer, resets to the idle level.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall     = rx_prev && !rx_sync;  // start bit edge.
  assign half_bit = ({1'b0, div} + (div_width + 1)'(1)) >> 1;
  assign mid_hit  = ({1'b0, baud_cnt} + (div_width + 1)'(1)) >= half_bit;
  assign bit_end  = (baud_cnt == div);  // one full bit later.

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state       <= rx_idle;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;  // single cycle pulse.
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          if (fall) state <= rx_start;
        end
        rx_start: begin
          if (mid_hit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // glitch, not a start bit.
            state    <= rx_sync ? rx_idle : rx_bits;
          end else begin
            baud_cnt <= baud_cnt + div_width'(1);
          end
        end
        rx_bits: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= rx_stop; // last data bit.
          end else begin
            baud_cnt <= baud_cnt + div_width'(1);
          end
        end
        rx_stop: begin
          if (bit_end) begin
            frame_valid <= 1'b1;
            state       <= rx_idle;
          end else begin
            baud_cnt <= baud_cnt + div_width'(1);
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // data path, lsb arrives first.
  always_ff @(posedge clk) begin
    if (state == rx_bits && bit_end) shift <= {rx_sync, shift[7:1]};
  end

  always_ff @(posedge clk) begin
    if (state == rx_stop && bit_end) begin
      frame.data      <= shift;
      frame.frame_err <= !rx_sync;  // stop must be high.
    end
  end

  // a frame takes many bit times, so never two pulses in a row.
  a_one_pulse: assert property (@(posedge clk) disable iff (!rest)
    frame_valid |=> !frame_valid);

endmodule

/* hw/uart.sv */
`timescale 1ns/1ps

module uart #(
  parameter int div_width = 16
) (
  input  logic               clk,
  input  logic               rest,
  input  uart_pkg::avl_req_t avl_req,
  output uart_pkg::avl_rsp_t avl_rsp,
  input  logic               rx,
  output logic               tx
);
  import uart_pkg::*;

  logic [div_width-1:0] div;       // shared by both serial stages.
  logic [7:0]           tx_byte;
  logic                 tx_start;
  logic                 tx_idle;
  logic                 frame_valid;
  rx_frame_t            frame;

  // receive stage.
  uart_rx #(.div_width(div_width)) rx_i (
    .clk        (clk),
    .rest       (rest),
    .div        (div),
    .rx         (rx),
    .frame_valid(frame_valid),
    .frame      (frame)
  );

  // register stage, bus slave.
  uart_regs #(.div_width(div_width)) regs_i (
    .clk        (clk),
    .rest       (rest),
    .avl_req    (avl_req),
    .avl_rsp    (avl_rsp),
    .div        (div),
    .tx_byte    (tx_byte),
    .tx_start   (tx_start),
    .tx_idle    (tx_idle),
    .frame_valid(frame_valid),
    .frame      (frame)
  );

  // transmit stage.
  uart_tx #(.div_width(div_width)) tx_i (
    .clk     (clk),
    .rest    (rest),
    .div     (div),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_idle (tx_idle)
  );

endmodule

/* dv/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;
  import uart_pkg::*;

  localparam int div_width = 16;
  localparam int n_rows    = 6;
  localparam int max_wait  = 4000;  // negedges or polls per wait.

  // one stimulus case.
  typedef struct packed {
    logic [15:0] div;
    logic [7:0]  data;
    logic        rnd;    // data replaced by a random byte.
    logic [1:0]  src;    // 0 loopback, 1 tb good stop, 2 tb bad stop.
    logic [2:0]  flags;  // expected {overrun, frame_err, rx_valid}.
    logic [1:0]  inc;    // expected count step.
  } row_t;

  logic        clk = 1'b0;
  logic        rest;
  avl_req_t    avl_req;
  avl_rsp_t    avl_rsp;
  logic        rx;
  logic        tx;
  logic        rx_drv;   // serial driver level.
  logic        loop_en;  // tx fed back into rx.

  row_t        table_rows [n_rows];
  row_t        row;
  int          errors;
  int          timeouts;
  logic [31:0] lfsr_state;
  logic [31:0] rd;
  logic [7:0]  model_count;  // frames the registers should have counted.
  logic [7:0]  b;
  logic [7:0]  b2;
  logic [15:0] d;

  assign rx = loop_en ? tx : rx_drv;

  uart #(.div_width(div_width)) uart_i (
    .clk    (clk),
    .rest   (rest),
    .avl_req(avl_req),
    .avl_rsp(avl_rsp),
    .rx     (rx),
    .tx     (tx)
  );

  always #50 clk = ~clk;  // 100 ns period.

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] v);
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];  // one step per bit.
    end
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // all bus tasks start and end on a falling edge.
  task automatic bus_write(input reg_addr_e sel, input logic [31:0] data);
    avl_req.write      = 1'b1;
    avl_req.address    = {sel, 2'b00};
    avl_req.write_data = data;
    @(negedge clk);
    avl_req.write = 1'b0;
  endtask

  task automatic bus_read(input reg_addr_e sel, output logic [31:0] data);
    int n;
    n = 0;
    avl_req.read    = 1'b1;
    avl_req.address = {sel, 2'b00};
    @(negedge clk);
    avl_req.read = 1'b0;
    while (!avl_rsp.read_data_valid && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (avl_rsp.read_data_valid) begin
      data = avl_rsp.read_data;
    end else begin
      $display("timeout: no read_data_valid for register %0d", sel);
      timeouts++;
      data = '0;
    end
  endtask

  // poll status until any masked bit is set.
  task automatic wait_status(input logic [31:0] mask, output logic [31:0] st);
    int n;
    n = 0;
    bus_read(reg_status, st);
    while ((st & mask) == 32'd0 && n < max_wait) begin
      bus_read(reg_status, st);
      n++;
    end
    if ((st & mask) == 32'd0) begin
      $display("timeout: status never showed any of bits %h", mask);
      timeouts++;
    end
  endtask

  task automatic wait_tx_low();
    int n;
    n = 0;
    while (tx !== 1'b0 && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0) begin
      $display("timeout: tx never showed a start bit");
      timeouts++;
    end
  endtask

  // 8n1 frame on rx, then idle long enough for the stop sample to land.
  task automatic send_frame(input logic [7:0] v, input logic stop, input int bit_len);
    logic [9:0] f;
    f = {stop, v, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_drv = f[i];
      repeat (bit_len) @(negedge clk);
    end
    rx_drv = 1'b1;
    repeat (3 * bit_len) @(negedge clk);
  endtask

  initial begin
    rest        = 1'b0;
    avl_req     = '0;
    rx_drv      = 1'b1;
    loop_en     = 1'b0;
    errors      = 0;
    timeouts    = 0;
    model_count = 8'd0;
    lfsr_state  = 32'he18e;
    table_rows[0] = '{16'd3,  8'h00, 1'b1, 2'd0, 3'b001, 2'd1};
    table_rows[1] = '{16'd7,  8'h00, 1'b1, 2'd0, 3'b001, 2'd1};
    table_rows[2] = '{16'd15, 8'h00, 1'b1, 2'd0, 3'b001, 2'd1};
    table_rows[3] = '{16'd5,  8'ha5, 1'b0, 2'd1, 3'b001, 2'd1};
    table_rows[4] = '{16'd5,  8'h3c, 1'b0, 2'd2, 3'b010, 2'd0};  // low stop bit.
    table_rows[5] = '{16'd9,  8'h00, 1'b1, 2'd1, 3'b001, 2'd1};
    repeat (10) @(negedge clk);
    rest = 1'b1;
    @(negedge clk);

    // reset values and divisor readback.
    check({31'd0, avl_rsp.request_ready}, 32'd1, "request_ready");
    bus_read(reg_status, rd);
    check(rd, 32'h1, "status after reset");
    bus_read(reg_div, rd);
    check(rd, 32'h0, "div after reset");
    bus_read(reg_count, rd);
    check(rd, 32'h0, "count after reset");
    bus_write(reg_div, 32'h0000_a5c3);
    bus_read(reg_div, rd);
    check(rd, 32'h0000_a5c3, "div readback");

    // tx bits sampled at their centers with loopback off.
    d = 16'd3;
    bus_write(reg_div, {16'd0, d});
    rand_byte(b);
    bus_write(reg_data, {24'd0, b});
    wait_tx_low();                        // half a cycle into the start bit.
    repeat ((d + 1) / 2) @(negedge clk);
    check({31'd0, tx}, 32'd0, "tx start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (d + 1) @(negedge clk);
      check({31'd0, tx}, {31'd0, b[i]}, "tx data bit");
    end
    repeat (d + 1) @(negedge clk);
    check({31'd0, tx}, 32'd1, "tx stop bit");

    // tx_idle low for exactly 10 bit times.
    wait_status(32'h1, rd);
    bus_write(reg_data, 32'h0000_005a);
    wait_tx_low();
    bus_read(reg_status, rd);  // first frame cycle.
    check(rd & 32'h1, 32'h0, "tx_idle low during frame");
    repeat (10 * (d + 1) - 2) @(negedge clk);
    bus_read(reg_status, rd);  // last frame cycle.
    check(rd & 32'h1, 32'h0, "tx_idle low in last cycle");
    bus_read(reg_status, rd);  // first idle cycle.
    check(rd & 32'h1, 32'h1, "tx_idle back after 10 bits");

    // table cases.
    for (int r = 0; r < n_rows; r++) begin
      row = table_rows[r];
      wait_status(32'h1, rd);  // tx done before div moves.
      bus_write(reg_div, {16'd0, row.div});
      b = row.data;
      if (row.rnd) rand_byte(b);
      loop_en = (row.src == 2'd0);
      if (row.src == 2'd0) bus_write(reg_data, {24'd0, b});
      else send_frame(b, row.src == 2'd1, int'(row.div) + 1);
      wait_status(32'h6, rd);  // rx_valid or frame_err.
      check({29'd0, rd[3:1]}, {29'd0, row.flags}, "status flags");
      if (row.flags[0]) begin
        bus_read(reg_data, rd);
        check(rd, {24'd0, b}, "received byte");
      end
      bus_read(reg_status, rd);
      check({29'd0, rd[3:1]}, 32'd0, "flags after consuming the frame");
      model_count = model_count + {6'd0, row.inc};
      bus_read(reg_count, rd);
      check(rd, {24'd0, model_count}, "frame count");
    end

    // overrun from two frames with no data read between.
    wait_status(32'h1, rd);
    loop_en = 1'b0;
    bus_write(reg_div, 32'd5);
    rand_byte(b);
    rand_byte(b2);
    send_frame(b, 1'b1, 6);
    send_frame(b2, 1'b1, 6);
    bus_read(reg_status, rd);
    check(rd, 32'h0000_000b, "status after overrun");
    bus_read(reg_data, rd);
    check(rd, {24'd0, b2}, "second byte kept");
    model_count = model_count + 8'd2;
    bus_read(reg_count, rd);
    check(rd, {24'd0, model_count}, "count after overrun");
    bus_read(reg_status, rd);
    check(rd, 32'h1, "overrun cleared by status read");

    // write while busy is dropped.
    bus_write(reg_div, 32'd4);
    loop_en = 1'b1;
    rand_byte(b);
    b2 = ~b;
    bus_write(reg_data, {24'd0, b});
    wait_tx_low();
    bus_write(reg_data, {24'd0, b2});
    wait_status(32'h2, rd);
    bus_read(reg_data, rd);
    check(rd, {24'd0, b}, "first byte after busy write");
    wait_status(32'h1, rd);
    repeat (30 * 5) @(negedge clk);  // room for a frame that must not come.
    bus_read(reg_status, rd);
    check(rd, 32'h1, "no second frame");
    model_count = model_count + 8'd1;
    bus_read(reg_count, rd);
    check(rd, {24'd0, model_count}, "count after busy write");

    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/uart_pkg.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart.sv
dv/uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it, and check the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module uart_tb \
  -Mdir obj_dir \
  -f verilog.f

# A nonzero exit from the simulation (e.g. an assertion) stops the script here.
./obj_dir/Vuart_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
exit 0
